/* files.f */
hdl/qv_pkg.sv
hdl/qv_prefetch.sv
hdl/qv_decode.sv
hdl/qv_regfile.sv
hdl/qv_execute.sv
hdl/qv_cpu.sv
testbench/qv_cpu_assertions.sv
testbench/qv_cpu_tb.sv

/* hdl/qv_cpu.sv */
// CPU top level: prefetch, decode, execute and register file
`timescale 1ns/1ps
`default_nettype none

module qv_cpu (
    input  logic              clk,
    input  logic              rstn,
    output logic              fetch_req,
    output qv_pkg::haddr_t    fetch_addr,
    input  logic              fetch_valid,
    input  qv_pkg::half_t     fetch_data,
    output logic              retire,
    output qv_pkg::haddr_t    retire_pc,
    output qv_pkg::reg_addr_t retire_rd,
    output logic              retire_wen,
    output qv_pkg::word_t     retire_data
);
    import qv_pkg::*;

    logic      instr_avail;
    word_t     instr_word;
    haddr_t    instr_pc;
    logic      instr_take;

    logic      dec_valid;
    logic      dec_take;
    alu_op_t   dec_op;
    reg_addr_t dec_rs1;
    reg_addr_t dec_rs2;
    reg_addr_t dec_rd;
    word_t     dec_imm;
    logic      dec_use_imm;
    logic      dec_wen;
    logic      dec_is_jal;
    haddr_t    dec_pc;

    logic      redirect;
    haddr_t    redirect_addr;

    reg_addr_t rf_raddr1;
    reg_addr_t rf_raddr2;
    word_t     rf_rdata1;
    word_t     rf_rdata2;
    logic      rf_wen;
    reg_addr_t rf_waddr;
    word_t     rf_wdata;

    qv_prefetch prefetch_i (
        .clk, .rstn, .fetch_valid, .fetch_data, .instr_take, .redirect, .redirect_addr,
        .fetch_req, .fetch_addr, .instr_avail, .instr_word, .instr_pc
    );

    qv_decode decode_i (
        .clk, .rstn, .instr_avail, .instr_word, .instr_pc, .dec_take, .redirect,
        .instr_take, .dec_valid, .dec_op, .dec_rs1, .dec_rs2, .dec_rd, .dec_imm,
        .dec_use_imm, .dec_wen, .dec_is_jal, .dec_pc
    );

    qv_execute execute_i (
        .clk, .rstn, .dec_valid, .dec_op, .dec_rs1, .dec_rs2, .dec_rd, .dec_imm,
        .dec_use_imm, .dec_wen, .dec_is_jal, .dec_pc, .rf_rdata1, .rf_rdata2,
        .dec_take, .rf_raddr1, .rf_raddr2, .rf_wen, .rf_waddr, .rf_wdata,
        .redirect, .redirect_addr, .retire, .retire_pc, .retire_rd, .retire_wen,
        .retire_data
    );

    qv_regfile regfile_i (
        .clk, .rstn, .rf_raddr1, .rf_raddr2, .rf_wen, .rf_waddr, .rf_wdata,
        .rf_rdata1, .rf_rdata2
    );

endmodule

`default_nettype wire

/* hdl/qv_decode.sv */
// Decode stage: RV32E subset decoder and decode register
`timescale 1ns/1ps
`default_nettype none

module qv_decode (
    input  logic              clk,
    input  logic              rstn,
    input  logic              instr_avail,
    input  qv_pkg::word_t     instr_word,
    input  qv_pkg::haddr_t    instr_pc,
    input  logic              dec_take,
    input  logic              redirect,
    output logic              instr_take,
    output logic              dec_valid,
    output qv_pkg::alu_op_t   dec_op,
    output qv_pkg::reg_addr_t dec_rs1,
    output qv_pkg::reg_addr_t dec_rs2,
    output qv_pkg::reg_addr_t dec_rd,
    output qv_pkg::word_t     dec_imm,
    output logic              dec_use_imm,
    output logic              dec_wen,
    output logic              dec_is_jal,
    output qv_pkg::haddr_t    dec_pc
);
    import qv_pkg::*;

    logic [6:0] opcode;
    logic [2:0] funct3;
    logic [6:0] funct7;
    logic       rd_ok;
    logic       rs1_ok;
    logic       rs2_ok;
    alu_op_t    op_d;
    word_t      imm_d;
    logic       use_imm_d;
    logic       wen_d;
    logic       jal_d;

    assign opcode = instr_word[6:0];
    assign funct3 = instr_word[14:12];
    assign funct7 = instr_word[31:25];

    // RV32E has no x16 and up
    assign rd_ok  = !instr_word[11];
    assign rs1_ok = !instr_word[19];
    assign rs2_ok = !instr_word[24];

    assign instr_take = instr_avail && (!dec_valid || dec_take) && !redirect;

    always_comb begin
        op_d      = ALU_PASS;
        imm_d     = {{20{instr_word[31]}}, instr_word[31:20]};
        use_imm_d = 1'b0;
        wen_d     = 1'b0;
        jal_d     = 1'b0;
        case (opcode)
            OPC_OP: begin
                if (funct7 == 7'h00 || (funct7 == 7'h20 && funct3 == 3'b000)) begin
                    wen_d = rd_ok && rs1_ok && rs2_ok;
                    case (funct3)
                        3'b000:  op_d = funct7[5] ? ALU_SUB : ALU_ADD;
                        3'b100:  op_d = ALU_XOR;
                        3'b110:  op_d = ALU_OR;
                        3'b111:  op_d = ALU_AND;
                        default: wen_d = 1'b0;   // Shifts and compares
                    endcase
                end
            end
            OPC_OP_IMM: begin
                use_imm_d = 1'b1;
                wen_d     = rd_ok && rs1_ok;
                case (funct3)
                    3'b000:  op_d = ALU_ADD;
                    3'b100:  op_d = ALU_XOR;
                    3'b110:  op_d = ALU_OR;
                    3'b111:  op_d = ALU_AND;
                    default: wen_d = 1'b0;
                endcase
            end
            OPC_LUI: begin
                imm_d     = {instr_word[31:12], 12'b0};
                use_imm_d = 1'b1;
                wen_d     = rd_ok;
            end
            OPC_JAL: begin
                imm_d = {{11{instr_word[31]}}, instr_word[31], instr_word[19:12],
                         instr_word[20], instr_word[30:21], 1'b0};
                wen_d = rd_ok;
                jal_d = rd_ok;   // Link operand comes from the execute stage
            end
            default: ;
        endcase
    end

    always_ff @(posedge clk) begin
        if (!rstn) begin
            dec_valid <= 1'b0;
        end else if (redirect) begin
            dec_valid <= 1'b0;
        end else if (instr_take) begin
            dec_valid <= 1'b1;
        end else if (dec_take) begin
            dec_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (instr_take) begin
            dec_op      <= op_d;
            dec_rs1     <= instr_word[18:15];
            dec_rs2     <= instr_word[23:20];
            dec_rd      <= instr_word[10:7];
            dec_imm     <= imm_d;
            dec_use_imm <= use_imm_d;
            dec_wen     <= wen_d;
            dec_is_jal  <= jal_d;
            dec_pc      <= instr_pc;
        end
    end

endmodule

`default_nettype wire

/* hdl/qv_execute.sv */
// Execute stage: nibble-serial ALU with carry chain, JAL link and target, write-back and retire
`timescale 1ns/1ps
`default_nettype none

module qv_execute (
    input  logic              clk,
    input  logic              rstn,
    input  logic              dec_valid,
    input  qv_pkg::alu_op_t   dec_op,
    input  qv_pkg::reg_addr_t dec_rs1,
    input  qv_pkg::reg_addr_t dec_rs2,
    input  qv_pkg::reg_addr_t dec_rd,
    input  qv_pkg::word_t     dec_imm,
    input  logic              dec_use_imm,
    input  logic              dec_wen,
    input  logic              dec_is_jal,
    input  qv_pkg::haddr_t    dec_pc,
    input  qv_pkg::word_t     rf_rdata1,
    input  qv_pkg::word_t     rf_rdata2,
    output logic              dec_take,
    output qv_pkg::reg_addr_t rf_raddr1,
    output qv_pkg::reg_addr_t rf_raddr2,
    output logic              rf_wen,
    output qv_pkg::reg_addr_t rf_waddr,
    output qv_pkg::word_t     rf_wdata,
    output logic              redirect,
    output qv_pkg::haddr_t    redirect_addr,
    output logic              retire,
    output qv_pkg::haddr_t    retire_pc,
    output qv_pkg::reg_addr_t retire_rd,
    output logic              retire_wen,
    output qv_pkg::word_t     retire_data
);
    import qv_pkg::*;

    exec_state_t state;
    logic [2:0]  cnt;          // Nibble index, zero in the take cycle
    alu_op_t     ex_op;
    logic        ex_wen;
    logic        ex_jal;
    reg_addr_t   ex_rd;
    haddr_t      ex_pc;
    word_t       a_reg;
    word_t       b_reg;
    word_t       res_sr;
    word_t       tgt_sr;
    logic        carry;
    logic        tgt_carry;

    word_t       link;
    word_t       a_in;
    word_t       b_in;
    word_t       a_cur;
    word_t       b_cur;
    word_t       pc_word;
    alu_op_t     op_cur;
    nibble_t     a_nib;
    nibble_t     b_nib;
    nibble_t     b_eff;
    nibble_t     pc_nib;
    nibble_t     res_nib;
    logic        cin;
    logic        tcin;
    logic [4:0]  sum;
    logic [4:0]  tsum;
    logic        last;

    assign dec_take  = (state == EXEC_IDLE) && dec_valid;
    assign rf_raddr1 = dec_rs1;
    assign rf_raddr2 = dec_rs2;

    // JAL: A is the offset, B the link, target runs on a second chain
    assign link = {8'b0, dec_pc + haddr_t'(2), 1'b0};
    assign a_in = dec_is_jal ? dec_imm : rf_rdata1;
    assign b_in = dec_is_jal ? link : (dec_use_imm ? dec_imm : rf_rdata2);

    // Nibble 0 is processed straight from the decode register
    assign a_cur   = dec_take ? a_in : a_reg;
    assign b_cur   = dec_take ? b_in : b_reg;
    assign op_cur  = dec_take ? dec_op : ex_op;
    assign pc_word = {8'b0, (dec_take ? dec_pc : ex_pc), 1'b0};

    assign a_nib  = a_cur[{cnt, 2'b00} +: 4];
    assign b_nib  = b_cur[{cnt, 2'b00} +: 4];
    assign pc_nib = pc_word[{cnt, 2'b00} +: 4];

    assign cin   = dec_take ? (dec_op == ALU_SUB) : carry;   // SUB is A + ~B + 1
    assign tcin  = dec_take ? 1'b0 : tgt_carry;
    assign b_eff = (op_cur == ALU_SUB) ? ~b_nib : b_nib;
    assign sum   = {1'b0, a_nib} + {1'b0, b_eff} + 5'(cin);
    assign tsum  = {1'b0, a_nib} + {1'b0, pc_nib} + 5'(tcin);

    always_comb begin
        case (op_cur)
            ALU_ADD, ALU_SUB: res_nib = sum[3:0];
            ALU_AND:          res_nib = a_nib & b_nib;
            ALU_OR:           res_nib = a_nib | b_nib;
            ALU_XOR:          res_nib = a_nib ^ b_nib;
            default:          res_nib = b_nib;
        endcase
    end

    assign last = (state == EXEC_RUN) && (cnt == 3'(NIBBLES - 1));

    always_ff @(posedge clk) begin
        if (!rstn) begin
            state <= EXEC_IDLE;
            cnt   <= '0;
        end else begin
            case (state)
                EXEC_IDLE: begin
                    if (dec_take) begin
                        state <= EXEC_RUN;
                        cnt   <= cnt + 1'b1;
                    end
                end
                EXEC_RUN: begin
                    cnt <= cnt + 1'b1;   // Wraps back to zero after the last nibble
                    if (last) begin
                        state <= EXEC_IDLE;
                    end
                end
                default: state <= EXEC_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (dec_take) begin
            ex_op  <= dec_op;
            ex_wen <= dec_wen;
            ex_jal <= dec_is_jal;
            ex_rd  <= dec_rd;
            ex_pc  <= dec_pc;
            a_reg  <= a_in;
            b_reg  <= b_in;
        end
        if (dec_take || state == EXEC_RUN) begin
            carry     <= sum[4];
            tgt_carry <= tsum[4];
            res_sr    <= {res_nib, res_sr[31:4]};
            tgt_sr    <= {tsum[3:0], tgt_sr[31:4]};
        end
    end

    assign retire_data = {res_nib, res_sr[31:4]};
    assign retire      = last;
    assign retire_pc   = ex_pc;
    assign retire_rd   = ex_rd;
    assign retire_wen  = ex_wen;

    assign rf_wen   = last && ex_wen;
    assign rf_waddr = ex_rd;
    assign rf_wdata = retire_data;

    // Target bits 23:1 are complete after nibble 5
    assign redirect      = last && ex_jal;
    assign redirect_addr = tgt_sr[27:5];

endmodule

`default_nettype wire

/* hdl/qv_pkg.sv */
// Shared width typedefs, opcodes, ALU operation codes, execute state and fetch credit count
`default_nettype none

package qv_pkg;

    typedef logic [31:0] word_t;
    typedef logic [3:0]  nibble_t;
    typedef logic [15:0] half_t;
    typedef logic [22:0] haddr_t;     // Byte address bits 23:1
    typedef logic [3:0]  reg_addr_t;
    typedef logic [2:0]  alu_op_t;

    localparam alu_op_t ALU_ADD  = 3'd0;
    localparam alu_op_t ALU_SUB  = 3'd1;
    localparam alu_op_t ALU_AND  = 3'd2;
    localparam alu_op_t ALU_OR   = 3'd3;
    localparam alu_op_t ALU_XOR  = 3'd4;
    localparam alu_op_t ALU_PASS = 3'd5;   // Forwards operand B

    typedef enum logic {
        EXEC_IDLE,
        EXEC_RUN
    } exec_state_t;

    // Halfword buffer slots, also the credits held by the fetch port
    localparam int FETCH_CREDITS = 4;
    localparam int SLOT_BITS = $clog2(FETCH_CREDITS);
    typedef logic [$clog2(FETCH_CREDITS + 1) - 1:0] credit_t;

    localparam int NIBBLES = 8;
    localparam haddr_t RESET_PC = '0;

    // RV32 major opcodes
    localparam logic [6:0] OPC_OP     = 7'b0110011;
    localparam logic [6:0] OPC_OP_IMM = 7'b0010011;
    localparam logic [6:0] OPC_LUI    = 7'b0110111;
    localparam logic [6:0] OPC_JAL    = 7'b1101111;

endpackage

`default_nettype wire

/* hdl/qv_prefetch.sv */
// Prefetch stage: credit-based halfword fetch, four-slot ring buffer, stale return discard
`timescale 1ns/1ps
`default_nettype none

module qv_prefetch (
    input  logic           clk,
    input  logic           rstn,
    input  logic           fetch_valid,
    input  qv_pkg::half_t  fetch_data,
    input  logic           instr_take,
    input  logic           redirect,
    input  qv_pkg::haddr_t redirect_addr,
    output logic           fetch_req,
    output qv_pkg::haddr_t fetch_addr,
    output logic           instr_avail,
    output qv_pkg::word_t  instr_word,
    output qv_pkg::haddr_t instr_pc
);
    import qv_pkg::*;

    half_t   ring [FETCH_CREDITS];
    haddr_t  req_addr;      // Next halfword to request
    haddr_t  wr_addr;       // Address of the next accepted return
    haddr_t  rd_addr;       // Oldest buffered halfword
    haddr_t  rd_hi;
    credit_t credits;
    credit_t outstanding;
    credit_t stale;
    credit_t outstanding_left;
    logic    fetch_en;
    logic    drop;
    logic    accept;
    logic [SLOT_BITS:0] fill;

    assign fetch_req  = fetch_en && (credits != '0) && !redirect;
    assign fetch_addr = req_addr;

    assign drop   = fetch_valid && (stale != '0);
    assign accept = fetch_valid && (stale == '0) && !redirect;

    // Every return still owed after this cycle belongs to the old path
    assign outstanding_left = outstanding - credit_t'(fetch_valid);

    assign fill        = wr_addr[SLOT_BITS:0] - rd_addr[SLOT_BITS:0];
    assign instr_avail = fill > 1;
    assign rd_hi       = rd_addr + 1'b1;
    assign instr_word  = {ring[rd_hi[SLOT_BITS-1:0]], ring[rd_addr[SLOT_BITS-1:0]]};
    assign instr_pc    = rd_addr;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            fetch_en    <= 1'b0;
            credits     <= credit_t'(FETCH_CREDITS);
            outstanding <= '0;
            stale       <= '0;
            req_addr    <= RESET_PC;
            wr_addr     <= RESET_PC;
            rd_addr     <= RESET_PC;
        end else begin
            fetch_en <= 1'b1;
            if (redirect) begin
                // Buffer contents are dropped, so their credits come back at once
                outstanding <= outstanding_left;
                stale       <= outstanding_left;
                credits     <= credit_t'(FETCH_CREDITS) - outstanding_left;
                req_addr    <= redirect_addr;
                wr_addr     <= redirect_addr;
                rd_addr     <= redirect_addr;
            end else begin
                outstanding <= outstanding + credit_t'(fetch_req) - credit_t'(fetch_valid);
                if (drop) begin
                    stale <= stale - 1'b1;
                end
                credits <= credits - credit_t'(fetch_req) + credit_t'(drop)
                           + (instr_take ? credit_t'(2) : credit_t'(0));
                if (fetch_req) begin
                    req_addr <= req_addr + 1'b1;
                end
                if (accept) begin
                    wr_addr <= wr_addr + 1'b1;
                end
                if (instr_take) begin
                    rd_addr <= rd_addr + haddr_t'(2);   // One 32-bit instruction
                end
            end
        end
    end

    always_ff @(posedge clk) begin
        if (accept) begin
            ring[wr_addr[SLOT_BITS-1:0]] <= fetch_data;
        end
    end

endmodule

`default_nettype wire

/* hdl/qv_regfile.sv */
// Register file: sixteen words, two combinational reads, one write, x0 fixed at zero
`timescale 1ns/1ps
`default_nettype none

module qv_regfile (
    input  logic              clk,
    input  logic              rstn,
    input  qv_pkg::reg_addr_t rf_raddr1,
    input  qv_pkg::reg_addr_t rf_raddr2,
    input  logic              rf_wen,
    input  qv_pkg::reg_addr_t rf_waddr,
    input  qv_pkg::word_t     rf_wdata,
    output qv_pkg::word_t     rf_rdata1,
    output qv_pkg::word_t     rf_rdata2
);
    import qv_pkg::*;

    word_t regs [2**$bits(reg_addr_t)];

    always_ff @(posedge clk) begin
        if (!rstn) begin
            for (int i = 0; i < 2**$bits(reg_addr_t); i++) begin
                regs[i] <= '0;
            end
        end else if (rf_wen && rf_waddr != '0) begin
            regs[rf_waddr] <= rf_wdata;
        end
    end

    assign rf_rdata1 = (rf_raddr1 == '0) ? '0 : regs[rf_raddr1];
    assign rf_rdata2 = (rf_raddr2 == '0) ? '0 : regs[rf_raddr2];

endmodule

`default_nettype wire

/* testbench/qv_cpu_assertions.sv */
// Bound checks for the fetch credit limit, the retire and redirect pulses and reset behavior
`timescale 1ns/1ps
`default_nettype none

module qv_cpu_assertions (
    input logic clk,
    input logic rstn,
    input logic fetch_req,
    input logic fetch_valid,
    input logic retire,
    input logic redirect
);
    import qv_pkg::*;

    int in_flight;          // Requests not yet answered by memory
    int credit_errors;
    int retire_errors;
    int redirect_errors;
    int reset_errors;
    int error_total;

    assign error_total = credit_errors + retire_errors + redirect_errors + reset_errors;

    always_ff @(posedge clk) begin
        if (!rstn) begin
            in_flight <= 0;
        end else begin
            in_flight <= in_flight + int'(fetch_req) - int'(fetch_valid);
        end
    end

    credit_limit: assert property (@(posedge clk) disable iff (!rstn)
        in_flight + int'(fetch_req) <= FETCH_CREDITS)
        else begin
            $error("More fetch requests in flight than credits");
            credit_errors++;
        end

    retire_pulse: assert property (@(posedge clk) disable iff (!rstn) retire |=> !retire)
        else begin
            $error("retire held high for more than one cycle");
            retire_errors++;
        end

    // A redirect comes with the retire of its JAL and lasts one cycle
    redirect_pulse: assert property (@(posedge clk) disable iff (!rstn)
        redirect |-> retire ##1 !redirect)
        else begin
            $error("redirect without retire or longer than one cycle");
            redirect_errors++;
        end

    reset_quiet: assert property (@(posedge clk) !rstn |=> !fetch_req)
        else begin
            $error("fetch_req raised while reset is asserted");
            reset_errors++;
        end

endmodule

bind qv_cpu qv_cpu_assertions qv_cpu_assertions_i (
    .clk, .rstn, .fetch_req, .fetch_valid, .retire, .redirect
);

`default_nettype wire

/* testbench/qv_cpu_tb.sv */
// Testbench with clock, reset, random program, instruction memory model, reference and retire checks
`timescale 1ns/1ps
`default_nettype none

module qv_cpu_tb;
    import qv_pkg::*;

    localparam int     PROG_LEN     = 150;   // Random instructions before the final loop
    localparam int     PROG_HALVES  = 2 * (PROG_LEN + 1);
    localparam int     RESET_CYCLES = 16;
    localparam int     CYCLE_LIMIT  = PROG_LEN * (NIBBLES + 4 * 2) + RESET_CYCLES + 500;
    localparam haddr_t FINAL_PC     = haddr_t'(2 * PROG_LEN);

    bit          clk;
    logic        rstn;
    logic        fetch_req;
    haddr_t      fetch_addr;
    logic        fetch_valid;
    half_t       fetch_data;
    logic        retire;
    haddr_t      retire_pc;
    reg_addr_t   retire_rd;
    logic        retire_wen;
    word_t       retire_data;

    half_t       prog [PROG_HALVES];
    haddr_t      req_addr_q [$];
    int unsigned req_due_q [$];   // Cycle in which each answer is driven
    int unsigned cycle;
    word_t       ref_regs [16];
    haddr_t      ref_pc;
    logic        program_done;

    qv_cpu qv_cpu_i (
        .clk, .rstn, .fetch_req, .fetch_addr, .fetch_valid, .fetch_data,
        .retire, .retire_pc, .retire_rd, .retire_wen, .retire_data
    );

    always #50 clk = ~clk;

    always @(posedge clk) begin
        cycle <= cycle + 1;
    end

    task automatic stop_with_failure();
        $display("Testbench failed");
        $fatal(1, "Simulation stopped at the first error");
    endtask

    task automatic report_mismatch(input string name, input word_t got, input word_t exp);
        $display("FAILED %s: got 0x%08h, expected 0x%08h", name, got, exp);
        stop_with_failure();
    endtask

    function automatic half_t memory_half(input haddr_t addr);
        if (addr < haddr_t'(PROG_HALVES)) begin
            return prog[addr];
        end else begin
            return addr[15:0] ^ {addr[22:16], 9'h0a5};   // Fill past the program
        end
    endfunction

    function automatic word_t encode_jal(input logic [3:0] rd, input int offset);
        logic [20:0] off;
        off = 21'(offset);
        return {off[20], off[10:1], off[11], off[19:12], 1'b0, rd, 7'b1101111};
    endfunction

    function automatic logic [2:0] random_alu_funct3();
        case ($urandom_range(0, 3))
            0:       return 3'b000;
            1:       return 3'b100;
            2:       return 3'b110;
            default: return 3'b111;
        endcase
    endfunction

    function automatic word_t random_instr(input int index);
        int unsigned kind;
        int          skip;
        logic [31:0] r;
        logic [2:0]  f3;
        logic [6:0]  f7;
        kind = $urandom_range(0, 99);
        r    = $urandom();
        f3   = random_alu_funct3();
        f7   = (f3 == 3'b000 && r[31]) ? 7'h20 : 7'h00;   // SUB only beside ADD
        if (kind < 35) begin
            return {f7, 1'b0, r[23:20], 1'b0, r[18:15], f3, 1'b0, r[10:7], 7'b0110011};
        end else if (kind < 65) begin
            return {r[31:20], 1'b0, r[18:15], f3, 1'b0, r[10:7], 7'b0010011};
        end else if (kind < 78) begin
            return {r[31:12], 1'b0, r[10:7], 7'b0110111};
        end else if (kind < 88) begin
            skip = $urandom_range(2, 4);
            if (index + skip > PROG_LEN) begin
                skip = PROG_LEN - index;
            end
            return encode_jal(r[10:7], skip * 4);
        end
        case (r[1:0])
            2'd0:    return {r[31:7], 7'b0000011};   // Load
            2'd1:    return {7'h00, 1'b0, r[23:20], 1'b0, r[18:15], 3'b001, 1'b0, r[10:7],
                             7'b0110011};            // SLL
            2'd2:    return {r[31:20], 1'b0, r[18:15], 3'b000, 1'b1, r[10:7], 7'b0010011};
            default: return {7'h20, 1'b0, r[23:20], 1'b0, r[18:15], 3'b100, 1'b0, r[10:7],
                             7'b0110011};
        endcase
    endfunction

    task automatic build_program();
        word_t w;
        for (int i = 0; i < PROG_LEN; i++) begin
            w = random_instr(i);
            prog[2 * i]     = w[15:0];
            prog[2 * i + 1] = w[31:16];
        end
        w = encode_jal(4'd0, 0);   // Jump to itself
        prog[2 * PROG_LEN]     = w[15:0];
        prog[2 * PROG_LEN + 1] = w[31:16];
    endtask

    // Architectural result of the instruction at pc
    function automatic void expected_retire(input word_t regs [16], input haddr_t pc,
                                            output reg_addr_t rd, output logic wen,
                                            output word_t value, output haddr_t next_pc);
        word_t      instr;
        word_t      a;
        word_t      b;
        word_t      imm;
        word_t      target;
        logic [4:0] rd5;
        logic [4:0] rs1;
        logic [4:0] rs2;
        instr   = {memory_half(pc + 1'b1), memory_half(pc)};
        rd5     = instr[11:7];
        rs1     = instr[19:15];
        rs2     = instr[24:20];
        rd      = rd5[3:0];
        a       = regs[rs1[3:0]];
        b       = regs[rs2[3:0]];
        imm     = {{20{instr[31]}}, instr[31:20]};
        wen     = 1'b0;
        value   = '0;
        next_pc = pc + haddr_t'(2);
        case (instr[6:0])
            7'b0110011: begin
                if (!rd5[4] && !rs1[4] && !rs2[4]) begin
                    wen = 1'b1;
                    case ({instr[31:25], instr[14:12]})
                        {7'h00, 3'b000}: value = a + b;
                        {7'h20, 3'b000}: value = a - b;
                        {7'h00, 3'b100}: value = a ^ b;
                        {7'h00, 3'b110}: value = a | b;
                        {7'h00, 3'b111}: value = a & b;
                        default:         wen = 1'b0;
                    endcase
                end
            end
            7'b0010011: begin
                if (!rd5[4] && !rs1[4]) begin
                    wen = 1'b1;
                    case (instr[14:12])
                        3'b000:  value = a + imm;
                        3'b100:  value = a ^ imm;
                        3'b110:  value = a | imm;
                        3'b111:  value = a & imm;
                        default: wen = 1'b0;
                    endcase
                end
            end
            7'b0110111: begin
                wen   = !rd5[4];
                value = {instr[31:12], 12'b0};
            end
            7'b1101111: begin
                if (!rd5[4]) begin
                    wen     = 1'b1;
                    value   = word_t'({pc, 1'b0}) + 32'd4;
                    imm     = {{11{instr[31]}}, instr[31], instr[19:12], instr[20],
                               instr[30:21], 1'b0};
                    target  = word_t'({pc, 1'b0}) + imm;
                    next_pc = target[23:1];
                end
            end
            default: ;
        endcase
    endfunction

    // Memory takes requests mid-cycle and answers them in order after 1 to 4 cycles
    always @(negedge clk) begin : memory_request
        int unsigned due;
        if (fetch_req) begin
            due = cycle + $urandom_range(1, 4);
            if (req_due_q.size() != 0 && due <= req_due_q[$]) begin
                due = req_due_q[$] + 1;
            end
            req_addr_q.push_back(fetch_addr);
            req_due_q.push_back(due);
        end
    end

    initial begin : memory_response
        fetch_valid = 1'b0;
        fetch_data  = '0;
        forever begin
            @(posedge clk);
            #1;
            if (req_due_q.size() != 0 && req_due_q[0] <= cycle) begin
                fetch_valid = 1'b1;
                fetch_data  = memory_half(req_addr_q.pop_front());
                void'(req_due_q.pop_front());
            end else begin
                fetch_valid = 1'b0;
                fetch_data  = '0;
            end
        end
    end

    always @(negedge clk) begin : retire_check
        reg_addr_t exp_rd;
        logic      exp_wen;
        word_t     exp_data;
        haddr_t    exp_next;
        if (!rstn) begin
            assert (!retire) else begin
                $display("Retire pulse seen while reset is asserted");
                stop_with_failure();
            end
            assert (!fetch_req) else begin
                $display("Fetch request issued while reset is asserted");
                stop_with_failure();
            end
        end else if (retire && !program_done) begin
            expected_retire(ref_regs, ref_pc, exp_rd, exp_wen, exp_data, exp_next);
            assert (retire_pc == ref_pc)
                else report_mismatch("retire_pc", word_t'(retire_pc), word_t'(ref_pc));
            assert (retire_wen == exp_wen)
                else report_mismatch("retire_wen", word_t'(retire_wen), word_t'(exp_wen));
            if (exp_wen) begin
                assert (retire_rd == exp_rd)
                    else report_mismatch("retire_rd", word_t'(retire_rd), word_t'(exp_rd));
                assert (retire_data == exp_data)
                    else report_mismatch("retire_data", retire_data, exp_data);
                if (exp_rd != '0) begin
                    ref_regs[exp_rd] = exp_data;
                end
            end
            if (ref_pc == FINAL_PC) begin
                program_done = 1'b1;
            end
            ref_pc = exp_next;
        end
    end

    initial begin
        rstn         = 1'b0;
        program_done = 1'b0;
        ref_pc       = RESET_PC;
        void'($urandom(32188));
        for (int i = 0; i < 16; i++) begin
            ref_regs[i] = '0;
        end
        build_program();
        repeat (RESET_CYCLES) @(posedge clk);
        #1;
        rstn = 1'b1;
        while (!program_done && cycle < CYCLE_LIMIT
               && qv_cpu_i.qv_cpu_assertions_i.error_total == 0) begin
            @(posedge clk);
        end
        if (qv_cpu_i.qv_cpu_assertions_i.error_total != 0) begin
            $display("%0d protocol assertion failures",
                     qv_cpu_i.qv_cpu_assertions_i.error_total);
            stop_with_failure();
        end else if (!program_done) begin
            $display("Timeout after %0d cycles before the final loop retired", cycle);
            stop_with_failure();
        end else begin
            $display("Testbench passed");
            $finish;
        end
    end

endmodule

`default_nettype wire
